// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Major opcode, bits 6:0 of the instruction
    typedef logic [6:0] opcode_t;

    // Function field, bits 14:12 of the instruction
    typedef logic [2:0] fn3_t;

    localparam opcode_t LUI       = 7'b0110111;
    localparam opcode_t AUIPC     = 7'b0010111;
    localparam opcode_t JAL       = 7'b1101111;
    localparam opcode_t JALR      = 7'b1100111;
    localparam opcode_t BRANCH    = 7'b1100011;
    localparam opcode_t LOAD      = 7'b0000011;
    localparam opcode_t STORE     = 7'b0100011;
    localparam opcode_t ARITH_IMM = 7'b0010011;
    localparam opcode_t ARITH     = 7'b0110011;
    localparam opcode_t FENCE     = 7'b0001111;
    localparam opcode_t SYSTEM    = 7'b1110011;

    // ALU operand 1 source
    typedef enum logic [1:0] {
        ALU_RS1_RF,
        ALU_RS1_PC,
        ALU_RS1_ZERO
    } alu_rs1_sel_t;

    // ALU operand 2 source
    typedef enum logic [1:0] {
        ALU_RS2_RF,
        ALU_RS2_IMM_I,
        ALU_RS2_IMM_U,
        ALU_RS2_LINK
    } alu_rs2_sel_t;

    // Return address is pc plus one instruction
    localparam logic [31:0] LINK_OFFSET = 32'd4;

endpackage

// ==== rtl/issue_pkg.sv ====
package issue_pkg;

    typedef logic [31:0] word_t;

    // Extra top bit selects signed or unsigned compare
    typedef logic [32:0] alu_operand_t;

    typedef logic [4:0] reg_addr_t;

    // Execution unit numbering
    localparam int BRANCH_UNIT = 0;
    localparam int ALU_UNIT    = 1;
    localparam int LS_UNIT     = 2;
    localparam int GC_UNIT     = 3;
    localparam int MUL_UNIT    = 4;
    localparam int DIV_UNIT    = 5;

    localparam int NUM_UNITS = 6;

    typedef logic [NUM_UNITS-1:0] unit_vec_t;

endpackage

// ==== rtl/instr_classify.sv ====
`timescale 1ns/1ps

module instr_classify #(
    parameter bit USE_MUL = 1'b0,
    parameter bit USE_DIV = 1'b0
) (
    input  issue_pkg::word_t            instruction,
    output rv_isa_pkg::opcode_t         opcode,
    output rv_isa_pkg::fn3_t            fn3,
    output issue_pkg::unit_vec_t        unit_request,
    output logic                        uses_rs1,
    output logic                        uses_rs2,
    output logic                        illegal_instruction,
    output rv_isa_pkg::alu_rs1_sel_t    alu_rs1_sel,
    output rv_isa_pkg::alu_rs2_sel_t    alu_rs2_sel
);
    import rv_isa_pkg::*;
    import issue_pkg::*;

    logic mult_div_op;
    logic valid_opcode;

    //////////////////////////////
    // Field split
    assign opcode = instruction[6:0];
    assign fn3 = instruction[14:12];
    assign mult_div_op = instruction[25];

    //////////////////////////////
    // Unit request and ALU operand selects
    always_comb begin
        unit_request = '0;
        alu_rs1_sel = ALU_RS1_RF;
        alu_rs2_sel = ALU_RS2_RF;
        case (opcode)
            BRANCH: begin
                unit_request[BRANCH_UNIT] = 1'b1;
            end
            JAL, JALR: begin
                // ALU forms the link value pc + 4
                unit_request[BRANCH_UNIT] = 1'b1;
                unit_request[ALU_UNIT] = 1'b1;
                alu_rs1_sel = ALU_RS1_PC;
                alu_rs2_sel = ALU_RS2_LINK;
            end
            LUI: begin
                unit_request[ALU_UNIT] = 1'b1;
                alu_rs1_sel = ALU_RS1_ZERO;
                alu_rs2_sel = ALU_RS2_IMM_U;
            end
            AUIPC: begin
                unit_request[ALU_UNIT] = 1'b1;
                alu_rs1_sel = ALU_RS1_PC;
                alu_rs2_sel = ALU_RS2_IMM_U;
            end
            ARITH_IMM: begin
                unit_request[ALU_UNIT] = 1'b1;
                alu_rs2_sel = ALU_RS2_IMM_I;
            end
            ARITH: begin
                if (mult_div_op) begin
                    unit_request[MUL_UNIT] = USE_MUL & ~fn3[2];
                    unit_request[DIV_UNIT] = USE_DIV & fn3[2];
                end else begin
                    unit_request[ALU_UNIT] = 1'b1;
                end
            end
            LOAD, STORE: begin
                unit_request[LS_UNIT] = 1'b1;
            end
            SYSTEM, FENCE: begin
                unit_request[GC_UNIT] = 1'b1;
            end
            default: begin
                unit_request = '0;
            end
        endcase
    end

    //////////////////////////////
    // Register use
    assign uses_rs1 = !(opcode inside {LUI, AUIPC, JAL});
    assign uses_rs2 = opcode inside {BRANCH, STORE, ARITH};

    //////////////////////////////
    // Illegal check
    assign valid_opcode = opcode inside {LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE,
                                         ARITH_IMM, ARITH, FENCE, SYSTEM};

    // Multiply and divide are only legal when their unit is built in
    assign illegal_instruction = ~valid_opcode
        | ((opcode == ARITH) & mult_div_op & ((~fn3[2] & ~USE_MUL) | (fn3[2] & ~USE_DIV)));

endmodule

// ==== rtl/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                    fb_valid,
    input  logic                    id_available,
    input  logic                    issue_hold,
    input  logic                    fetch_flush,
    input  logic                    rs1_conflict,
    input  logic                    rs2_conflict,
    input  logic                    uses_rs1,
    input  logic                    uses_rs2,
    input  rv_isa_pkg::opcode_t     opcode,
    input  issue_pkg::unit_vec_t    unit_request,
    input  issue_pkg::unit_vec_t    unit_ready,
    input  logic                    illegal_instruction,
    output logic                    issued,
    output issue_pkg::unit_vec_t    unit_issue
);
    import rv_isa_pkg::*;
    import issue_pkg::*;

    logic issue_valid;
    logic units_ready;
    logic rs1_ready;
    logic rs2_ready;

    // Stage level conditions, independent of the instruction's units
    assign issue_valid = fb_valid & id_available & ~issue_hold & ~fetch_flush
                       & ~illegal_instruction;

    // Every requested unit must accept, and at least one must be requested
    assign units_ready = (|unit_request) & ~|(unit_request & ~unit_ready);

    assign rs1_ready = ~uses_rs1 | ~rs1_conflict;

    // Store data is forwarded in the load/store unit
    assign rs2_ready = ~uses_rs2 | ~rs2_conflict | (opcode == STORE);

    assign issued = issue_valid & units_ready & rs1_ready & rs2_ready;

    //////////////////////////////
    // Per-unit strobes
    assign unit_issue = unit_request & {NUM_UNITS{issued}};

endmodule

// ==== rtl/alu_operand_gen.sv ====
`timescale 1ns/1ps

module alu_operand_gen (
    input  rv_isa_pkg::alu_rs1_sel_t    alu_rs1_sel,
    input  rv_isa_pkg::alu_rs2_sel_t    alu_rs2_sel,
    input  issue_pkg::word_t            instruction,
    input  rv_isa_pkg::fn3_t            fn3,
    input  issue_pkg::word_t            pc,
    input  issue_pkg::word_t            rs1_data,
    input  issue_pkg::word_t            rs2_data,
    output issue_pkg::alu_operand_t     alu_in1,
    output issue_pkg::alu_operand_t     alu_in2
);
    import rv_isa_pkg::*;
    import issue_pkg::*;

    word_t rs1_op;
    word_t rs2_op;

    always_comb begin
        case (alu_rs1_sel)
            ALU_RS1_PC:   rs1_op = pc;
            ALU_RS1_ZERO: rs1_op = '0;
            default:      rs1_op = rs1_data;
        endcase
    end

    always_comb begin
        case (alu_rs2_sel)
            ALU_RS2_IMM_I: rs2_op = {{20{instruction[31]}}, instruction[31:20]};
            ALU_RS2_IMM_U: rs2_op = {instruction[31:12], 12'b0};
            ALU_RS2_LINK:  rs2_op = LINK_OFFSET;
            default:       rs2_op = rs2_data;
        endcase
    end

    //////////////////////////////
    // 33-bit extension
    // fn3[0] set marks the unsigned compares SLTU and SLTIU
    assign alu_in1 = {rs1_op[31] & ~fn3[0], rs1_op};
    assign alu_in2 = {rs2_op[31] & ~fn3[0], rs2_op};

endmodule

// ==== rtl/ls_operand_gen.sv ====
`timescale 1ns/1ps

module ls_operand_gen (
    input  rv_isa_pkg::opcode_t     opcode,
    input  rv_isa_pkg::fn3_t        fn3,
    input  issue_pkg::word_t        instruction,
    input  issue_pkg::word_t        rs1_data,
    output issue_pkg::word_t        ls_address,
    output logic                    ls_load,
    output logic                    ls_store,
    output rv_isa_pkg::fn3_t        ls_fn3
);
    import rv_isa_pkg::*;
    import issue_pkg::*;

    logic [11:0] ls_offset;
    word_t       offset_ext;

    // Opcode bit 5 separates the store form from the load form
    assign ls_offset = opcode[5] ? {instruction[31:25], instruction[11:7]}
                                 : instruction[31:20];

    assign offset_ext = {{20{ls_offset[11]}}, ls_offset};
    assign ls_address = rs1_data + offset_ext;

    assign ls_load = (opcode == LOAD);
    assign ls_store = (opcode == STORE);

    // Access width and sign
    assign ls_fn3 = fn3;

endmodule

// ==== rtl/gc_capture.sv ====
`timescale 1ns/1ps

module gc_capture (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    gc_issue,
    input  rv_isa_pkg::opcode_t     opcode,
    input  rv_isa_pkg::fn3_t        fn3,
    input  issue_pkg::word_t        instruction,
    input  issue_pkg::word_t        pc,
    input  issue_pkg::word_t        rs1_data,
    output issue_pkg::word_t        gc_pc,
    output issue_pkg::word_t        gc_instruction,
    output issue_pkg::word_t        gc_rs1,
    output logic                    gc_is_fence,
    output logic                    gc_is_csr,
    output logic                    gc_is_ecall,
    output logic                    gc_is_ebreak,
    output logic                    gc_is_ret,
    output logic                    gc_is_i_fence,
    output logic                    gc_flush_required
);
    import rv_isa_pkg::*;

    logic i_fence;
    logic environment_op;

    assign i_fence = (opcode == FENCE) & fn3[0];
    assign environment_op = (opcode == SYSTEM) & (fn3 == 3'b000);

    // Held until the next global-control issue
    always_ff @(posedge clk) begin
        if (gc_issue) begin
            gc_pc <= pc;
            gc_instruction <= instruction;
            gc_rs1 <= rs1_data;
            gc_is_fence <= (opcode == FENCE) & ~fn3[0];
            gc_is_csr <= (opcode == SYSTEM) & (fn3 != 3'b000);
        end
    end

    //////////////////////////////
    // Single-cycle pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            gc_is_ecall <= 1'b0;
            gc_is_ebreak <= 1'b0;
            gc_is_ret <= 1'b0;
            gc_is_i_fence <= 1'b0;
        end else begin
            gc_is_ecall <= gc_issue & environment_op & (instruction[21:20] == 2'b00);
            gc_is_ebreak <= gc_issue & environment_op & (instruction[21:20] == 2'b01);
            gc_is_ret <= gc_issue & environment_op & (instruction[21:20] == 2'b10);
            gc_is_i_fence <= gc_issue & i_fence;
        end
    end

    // Environment ops and I-fence redirect fetch
    assign gc_flush_required = gc_issue & (environment_op | i_fence);

endmodule

// ==== rtl/decode_issue.sv ====
`timescale 1ns/1ps

module decode_issue #(
    parameter bit USE_MUL = 1'b1,
    parameter bit USE_DIV = 1'b0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fb_valid,
    input  issue_pkg::word_t        instruction,
    input  issue_pkg::word_t        pc,
    input  issue_pkg::word_t        rs1_data,
    input  issue_pkg::word_t        rs2_data,
    input  logic                    rs1_conflict,
    input  logic                    rs2_conflict,
    input  logic                    id_available,
    input  logic                    issue_hold,
    input  logic                    fetch_flush,
    input  issue_pkg::unit_vec_t    unit_ready,
    output logic                    issued,
    output issue_pkg::unit_vec_t    unit_issue,
    output logic                    illegal_instruction,
    output issue_pkg::alu_operand_t alu_in1,
    output issue_pkg::alu_operand_t alu_in2,
    output issue_pkg::word_t        ls_address,
    output logic                    ls_load,
    output logic                    ls_store,
    output rv_isa_pkg::fn3_t        ls_fn3,
    output issue_pkg::word_t        gc_pc,
    output issue_pkg::word_t        gc_instruction,
    output issue_pkg::word_t        gc_rs1,
    output logic                    gc_is_fence,
    output logic                    gc_is_csr,
    output logic                    gc_is_ecall,
    output logic                    gc_is_ebreak,
    output logic                    gc_is_ret,
    output logic                    gc_is_i_fence,
    output logic                    gc_flush_required
);
    import rv_isa_pkg::*;
    import issue_pkg::*;

    opcode_t      opcode;
    fn3_t         fn3;
    unit_vec_t    unit_request;
    logic         uses_rs1;
    logic         uses_rs2;
    alu_rs1_sel_t alu_rs1_sel;
    alu_rs2_sel_t alu_rs2_sel;

    //////////////////////////////
    // Input side
    instr_classify #(
        .USE_MUL(USE_MUL),
        .USE_DIV(USE_DIV)
    ) classify0 (
        .instruction(instruction),
        .opcode(opcode),
        .fn3(fn3),
        .unit_request(unit_request),
        .uses_rs1(uses_rs1),
        .uses_rs2(uses_rs2),
        .illegal_instruction(illegal_instruction),
        .alu_rs1_sel(alu_rs1_sel),
        .alu_rs2_sel(alu_rs2_sel)
    );

    //////////////////////////////
    // Issue decision
    issue_ctrl issue0 (
        .fb_valid(fb_valid),
        .id_available(id_available),
        .issue_hold(issue_hold),
        .fetch_flush(fetch_flush),
        .rs1_conflict(rs1_conflict),
        .rs2_conflict(rs2_conflict),
        .uses_rs1(uses_rs1),
        .uses_rs2(uses_rs2),
        .opcode(opcode),
        .unit_request(unit_request),
        .unit_ready(unit_ready),
        .illegal_instruction(illegal_instruction),
        .issued(issued),
        .unit_issue(unit_issue)
    );

    //////////////////////////////
    // Operand formers
    alu_operand_gen alu_ops0 (
        .alu_rs1_sel(alu_rs1_sel),
        .alu_rs2_sel(alu_rs2_sel),
        .instruction(instruction),
        .fn3(fn3),
        .pc(pc),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .alu_in1(alu_in1),
        .alu_in2(alu_in2)
    );

    ls_operand_gen ls_ops0 (
        .opcode(opcode),
        .fn3(fn3),
        .instruction(instruction),
        .rs1_data(rs1_data),
        .ls_address(ls_address),
        .ls_load(ls_load),
        .ls_store(ls_store),
        .ls_fn3(ls_fn3)
    );

    gc_capture gc0 (
        .clk(clk),
        .rst(rst),
        .gc_issue(unit_issue[GC_UNIT]),
        .opcode(opcode),
        .fn3(fn3),
        .instruction(instruction),
        .pc(pc),
        .rs1_data(rs1_data),
        .gc_pc(gc_pc),
        .gc_instruction(gc_instruction),
        .gc_rs1(gc_rs1),
        .gc_is_fence(gc_is_fence),
        .gc_is_csr(gc_is_csr),
        .gc_is_ecall(gc_is_ecall),
        .gc_is_ebreak(gc_is_ebreak),
        .gc_is_ret(gc_is_ret),
        .gc_is_i_fence(gc_is_i_fence),
        .gc_flush_required(gc_flush_required)
    );

endmodule

// ==== verif/tb_decode_issue.sv ====
`timescale 1ns/1ps

module tb_decode_issue;

    localparam int MAX_VECTORS = 64;
    localparam string VECTOR_FILE = "verif/decode_issue_input.txt";

    // ECALL, EBREAK, MRET and FENCE.I, one per pulse output
    localparam logic [31:0] FLUSH_OPS [4] = '{32'h00000073, 32'h00100073, 32'h30200073,
                                              32'h0000100f};

    logic        clk;
    logic        rst;
    logic        fb_valid;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        rs1_conflict;
    logic        rs2_conflict;
    logic        id_available;
    logic        issue_hold;
    logic        fetch_flush;
    logic [5:0]  unit_ready;
    logic        issued;
    logic [5:0]  unit_issue;
    logic        illegal_instruction;
    logic [32:0] alu_in1;
    logic [32:0] alu_in2;
    logic [31:0] ls_address;
    logic        ls_load;
    logic        ls_store;
    logic [2:0]  ls_fn3;
    logic [31:0] gc_pc;
    logic [31:0] gc_instruction;
    logic [31:0] gc_rs1;
    logic        gc_is_fence;
    logic        gc_is_csr;
    logic        gc_is_ecall;
    logic        gc_is_ebreak;
    logic        gc_is_ret;
    logic        gc_is_i_fence;
    logic        gc_flush_required;

    // Vector storage, one entry per data line
    logic [31:0] instr_mem [MAX_VECTORS];
    logic [31:0] pc_mem [MAX_VECTORS];
    logic [31:0] rs1_mem [MAX_VECTORS];
    logic [31:0] rs2_mem [MAX_VECTORS];
    logic [5:0]  ctrl_mem [MAX_VECTORS];
    logic [5:0]  ready_mem [MAX_VECTORS];
    logic [1:0]  chk_mem [MAX_VECTORS];
    logic        exp_issued_mem [MAX_VECTORS];
    logic [5:0]  exp_unit_mem [MAX_VECTORS];
    logic        exp_illegal_mem [MAX_VECTORS];
    logic [32:0] exp_in1_mem [MAX_VECTORS];
    logic [32:0] exp_in2_mem [MAX_VECTORS];
    logic [31:0] exp_addr_mem [MAX_VECTORS];
    logic [4:0]  exp_ls_mem [MAX_VECTORS];
    logic [6:0]  exp_gc_mem [MAX_VECTORS];

    int num_vectors = 0;
    int vectors_ok = 1;
    int check_count = 0;
    int error_count = 0;
    int cycle_count = 0;
    int cycle_limit = 36;
    int vec;
    int reset_cycle;

    decode_issue #(
        .USE_MUL(1'b1),
        .USE_DIV(1'b0)
    ) dut0 (.*);

    always #2 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [32:0] actual,
                                 input logic [32:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0.1f ns: %s is %h, expected %h", $realtime, name, actual,
                     expected);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          status;
        string       line;
        logic [31:0] t_instr, t_pc, t_rs1, t_rs2, t_addr;
        logic [7:0]  t_ctrl, t_ready, t_chk, t_issued, t_unit, t_illegal, t_ls, t_gc;
        logic [32:0] t_in1, t_in2;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the vector file %s", VECTOR_FILE);
            vectors_ok = 0;
        end else begin
            while (!$feof(fd) && vectors_ok != 0) begin
                line = "";
                status = $fgets(line, fd);
                // Skip blank and comment lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    status = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                     t_instr, t_pc, t_rs1, t_rs2, t_ctrl, t_ready, t_chk,
                                     t_issued, t_unit, t_illegal, t_in1, t_in2, t_addr,
                                     t_ls, t_gc);
                    if (status != 15 || num_vectors == MAX_VECTORS) begin
                        $display("Vector %0d in the vector file could not be read",
                                 num_vectors + 1);
                        vectors_ok = 0;
                    end else begin
                        instr_mem[num_vectors] = t_instr;
                        pc_mem[num_vectors] = t_pc;
                        rs1_mem[num_vectors] = t_rs1;
                        rs2_mem[num_vectors] = t_rs2;
                        ctrl_mem[num_vectors] = t_ctrl[5:0];
                        ready_mem[num_vectors] = t_ready[5:0];
                        chk_mem[num_vectors] = t_chk[1:0];
                        exp_issued_mem[num_vectors] = t_issued[0];
                        exp_unit_mem[num_vectors] = t_unit[5:0];
                        exp_illegal_mem[num_vectors] = t_illegal[0];
                        exp_in1_mem[num_vectors] = t_in1;
                        exp_in2_mem[num_vectors] = t_in2;
                        exp_addr_mem[num_vectors] = t_addr;
                        exp_ls_mem[num_vectors] = t_ls[4:0];
                        exp_gc_mem[num_vectors] = t_gc[6:0];
                        num_vectors++;
                    end
                end
            end
            $fclose(fd);
            if (vectors_ok != 0 && num_vectors == 0) begin
                $display("The vector file holds no vectors");
                vectors_ok = 0;
            end
        end
    endtask

    task automatic apply_vector(input int i);
        // Operand fields are don't-care here, so any register data will do
        if (chk_mem[i] == 2'd0) begin
            rs1_mem[i] = $urandom();
            rs2_mem[i] = $urandom();
        end
        instruction = instr_mem[i];
        pc = pc_mem[i];
        rs1_data = rs1_mem[i];
        rs2_data = rs2_mem[i];
        fb_valid = ctrl_mem[i][5];
        rs1_conflict = ctrl_mem[i][4];
        rs2_conflict = ctrl_mem[i][3];
        id_available = ctrl_mem[i][2];
        issue_hold = ctrl_mem[i][1];
        fetch_flush = ctrl_mem[i][0];
        unit_ready = ready_mem[i];
    endtask

    task automatic inspect_outputs(input int i);
        compare_value("issued", 33'(issued), 33'(exp_issued_mem[i]));
        compare_value("unit_issue", 33'(unit_issue), 33'(exp_unit_mem[i]));
        compare_value("illegal_instruction", 33'(illegal_instruction),
                      33'(exp_illegal_mem[i]));
        compare_value("gc_flush_required", 33'(gc_flush_required), 33'(exp_gc_mem[i][0]));
        if (chk_mem[i][0]) begin
            compare_value("alu_in1", alu_in1, exp_in1_mem[i]);
            compare_value("alu_in2", alu_in2, exp_in2_mem[i]);
        end
        if (chk_mem[i][1]) begin
            compare_value("ls_address", 33'(ls_address), 33'(exp_addr_mem[i]));
            compare_value("ls_load", 33'(ls_load), 33'(exp_ls_mem[i][0]));
            compare_value("ls_store", 33'(ls_store), 33'(exp_ls_mem[i][1]));
            compare_value("ls_fn3", 33'(ls_fn3), 33'(exp_ls_mem[i][4:2]));
        end
    endtask

    // Registered view of vector k, one cycle after it was presented
    task automatic check_gc_state(input int k);
        compare_value("gc_is_ecall", 33'(gc_is_ecall), 33'(exp_gc_mem[k][3]));
        compare_value("gc_is_ebreak", 33'(gc_is_ebreak), 33'(exp_gc_mem[k][4]));
        compare_value("gc_is_ret", 33'(gc_is_ret), 33'(exp_gc_mem[k][5]));
        compare_value("gc_is_i_fence", 33'(gc_is_i_fence), 33'(exp_gc_mem[k][6]));
        if (exp_unit_mem[k][3]) begin
            compare_value("gc_pc", 33'(gc_pc), 33'(pc_mem[k]));
            compare_value("gc_instruction", 33'(gc_instruction), 33'(instr_mem[k]));
            compare_value("gc_rs1", 33'(gc_rs1), 33'(rs1_mem[k]));
            compare_value("gc_is_fence", 33'(gc_is_fence), 33'(exp_gc_mem[k][1]));
            compare_value("gc_is_csr", 33'(gc_is_csr), 33'(exp_gc_mem[k][2]));
        end
    endtask

    task automatic confirm_pulses_low();
        compare_value("gc_is_ecall", 33'(gc_is_ecall), 33'd0);
        compare_value("gc_is_ebreak", 33'(gc_is_ebreak), 33'd0);
        compare_value("gc_is_ret", 33'(gc_is_ret), 33'd0);
        compare_value("gc_is_i_fence", 33'(gc_is_i_fence), 33'd0);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        // Stage open for issue during reset
        fb_valid = 1'b1;
        instruction = '0;
        pc = '0;
        rs1_data = '0;
        rs2_data = '0;
        rs1_conflict = 1'b0;
        rs2_conflict = 1'b0;
        id_available = 1'b1;
        issue_hold = 1'b0;
        fetch_flush = 1'b0;
        unit_ready = '1;
        void'($urandom(78507));

        load_vectors();
        cycle_limit = num_vectors * 2 + 16 + 20;

        if (vectors_ok == 0) begin
            $display("CHECKS FAILED");
        end else begin
            // Each flushing op waits at issue while reset holds the pulses low
            for (reset_cycle = 0; reset_cycle < 16; reset_cycle++) begin
                instruction = FLUSH_OPS[reset_cycle % 4];
                @(posedge clk);
                @(negedge clk);
                confirm_pulses_low();
            end
            rst = 1'b0;

            for (vec = 0; vec < num_vectors; vec++) begin
                if (vec > 0) begin
                    check_gc_state(vec - 1);
                end
                apply_vector(vec);
                #1.5;
                inspect_outputs(vec);
                @(negedge clk);
            end
            check_gc_state(num_vectors - 1);

            $display("Checks run: %0d, errors: %0d", check_count, error_count);
            if (error_count == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
        end
        $finish;
    end

endmodule

// ==== decode_issue.f ====
rtl/rv_isa_pkg.sv
rtl/issue_pkg.sv
rtl/instr_classify.sv
rtl/issue_ctrl.sv
rtl/alu_operand_gen.sv
rtl/ls_operand_gen.sv
rtl/gc_capture.sv
rtl/decode_issue.sv
verif/tb_decode_issue.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_decode_issue
FILELIST  = decode_issue.f

SOURCES = $(shell grep -v '^+' $(FILELIST))
BIN     = obj_dir/V$(TOP)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== verif/decode_issue_input.txt ====
# instr pc rs1 rs2 ctrl(fb_valid,rs1_conf,rs2_conf,id_avail,hold,flush) ready chk(1 alu,2 ls)
# exp: issued unit_issue illegal alu_in1 alu_in2 ls_address ls(fn3,store,load) gc(ifence,ret,ebreak,ecall,csr,fence,flush)
fff10093 00001000 00000010 12345678 24 3f 1 1 02 0 000000010 1ffffffff 00000000 00 00
ffe23193 00001004 80000000 00000000 24 3f 1 1 02 0 080000000 0fffffffe 00000000 00 00
abcde2b7 00001008 00000000 00000000 34 3f 1 1 02 0 000000000 1abcde000 00000000 00 00
00012317 80000100 00000000 00000000 24 3f 1 1 02 0 180000100 000012000 00000000 00 00
008000ef 00002000 00000000 00000000 3c 3f 1 1 03 0 000002000 000000004 00000000 00 00
000280e7 00003000 00000000 00000000 24 3f 1 1 03 0 000003000 000000004 00000000 00 00
009403b3 00001010 7fffffff 80000001 24 3f 1 1 02 0 07fffffff 180000001 00000000 00 00
009433b3 00001014 ffffffff 00000001 24 3f 1 1 02 0 0ffffffff 000000001 00000000 00 00
00208463 00001018 00000000 00000000 24 3f 0 1 01 0 000000000 000000000 00000000 00 00
009403b3 0000101c 00000000 00000000 2c 3f 0 0 00 0 000000000 000000000 00000000 00 00
009403b3 0000101c 00000000 00000000 34 3f 0 0 00 0 000000000 000000000 00000000 00 00
ffc5a503 00001020 00001000 00000000 24 3f 2 1 04 0 000000000 000000000 00000ffc 09 00
00c6a823 00001024 20000000 00000000 2c 3f 2 1 04 0 000000000 000000000 20000010 0a 00
fee78fa3 00001028 00000100 00000000 24 3f 2 1 04 0 000000000 000000000 000000ff 02 00
ffc5a503 0000102c 00001000 00000000 24 3b 2 0 00 0 000000000 000000000 00000ffc 09 00
023100b3 00001030 00000000 00000000 24 3f 0 1 10 0 000000000 000000000 00000000 00 00
023100b3 00001030 00000000 00000000 24 2f 0 0 00 0 000000000 000000000 00000000 00 00
023140b3 00001034 00000000 00000000 24 3f 0 0 00 1 000000000 000000000 00000000 00 00
0000007f 00001038 00000000 00000000 24 3f 0 0 00 1 000000000 000000000 00000000 00 00
fff10093 0000103c 00000000 00000000 04 3f 0 0 00 0 000000000 000000000 00000000 00 00
fff10093 0000103c 00000000 00000000 20 3f 0 0 00 0 000000000 000000000 00000000 00 00
fff10093 0000103c 00000000 00000000 26 3f 0 0 00 0 000000000 000000000 00000000 00 00
fff10093 0000103c 00000000 00000000 25 3f 0 0 00 0 000000000 000000000 00000000 00 00
300110f3 00004000 00000000 00000000 24 3f 0 1 08 0 000000000 000000000 00000000 00 04
00000073 00004004 00000000 00000000 24 3f 0 1 08 0 000000000 000000000 00000000 00 09
00100073 00004008 00000000 00000000 24 3f 0 1 08 0 000000000 000000000 00000000 00 11
30200073 0000400c 00000000 00000000 24 3f 0 1 08 0 000000000 000000000 00000000 00 21
0ff0000f 00004010 00000000 00000000 24 3f 0 1 08 0 000000000 000000000 00000000 00 02
0000100f 00004014 00000000 00000000 24 3f 0 1 08 0 000000000 000000000 00000000 00 41
00000073 00004018 00000000 00000000 24 37 0 0 00 0 000000000 000000000 00000000 00 00
